// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = tb_mov_core
FILELIST = files.f
BUILD = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, search the log for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== files.f ====
verilog/core_pkg.sv
verilog/isa_pkg.sv
verilog/issue_unit.sv
verilog/gpr_rename_file.sv
verilog/mov_station.sv
verilog/cdb_arbiter.sv
verilog/mov_core.sv
test/tb_mov_core.sv

// ==== test/mov_core_tests.txt ====
// Words from 0: delay in cycles for an external op (2 hex digits), then the instruction word
// Words from 40 hex: expected final values of r0 to r15; opcode 3 ends the program
0004001234 000800fff0 004c400000 // r1 = 1234, r2 = -16, r3 = r1
0690000000 0055000000 0059400000 // ext r4, r5 = r4, r6 = r5
029c000000 0061c00000 0024008000 // ext r7, r8 = r7, r9 = 8000
0028007fff 006c800000 10b0000000 // r10 = 7fff, r11 = r2, ext r12
0077000000 01b8000000 003c00beef // r13 = r12, ext r14, r15 = beef
00100000a5 0054400000 001800c000 // r4 = a5, r5 = r1, r6 = c000
005e800000 0020000001 0072400000 // r7 = r10, r8 = 1, r12 = r9
0074c00000 003800ff00 ffffffffff // r13 = r3, r14 = ff00, end of program
@40
00000000 00001234 fffffff0 00001234
000000a5 00001234 ffffc000 00007fff
00000001 ffff8000 00007fff fffffff0
ffff8000 00001234 ffffff00 ffffbeef

// ==== test/tb_mov_core.sv ====
`default_nettype none

module tb_mov_core;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int exp_base = 64;

	logic clk;
	logic reset;
	logic insn_valid;
	logic insn_ready;
	isa_pkg::insn_t insn;
	logic ext_issue_valid;
	core_pkg::tag_t ext_issue;
	core_pkg::cdb_t ext_result;
	logic ext_result_ready;
	core_pkg::cdb_t cdb_out;

	logic [39:0] tests [0:exp_base+15];
	int n_prog;
	int n_lines = 0;
	logic [7:0] cur_delay;

	// Reference model, renamed in program order
	logic [31:0] ref_reg [16];
	logic [31:0] exp_val [8];
	logic pending [8];
	logic readback [8];
	logic [3:0] rb_reg [8];
	core_pkg::tag_t ref_tag;
	int outstanding;
	logic stall_seen;
	logic rb_phase;

	// External unit model
	logic [31:0] lfsr;
	int cycle;
	core_pkg::tag_t ext_tag_q [$];
	logic [31:0] ext_val_q [$];
	int ext_due_q [$];
	logic ext_taken;

	mov_core #(.n_entry(2)) u_dut (
		.clk(clk), .reset(reset),
		.insn_valid(insn_valid), .insn_ready(insn_ready), .insn(insn),
		.ext_issue_valid(ext_issue_valid), .ext_issue(ext_issue),
		.ext_result(ext_result), .ext_result_ready(ext_result_ready),
		.cdb_out(cdb_out)
	);

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] next_random(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
		end
		return v;
	endfunction

	task automatic send_insn(input logic [31:0] word, input logic [7:0] delay);
		insn_valid = 1'b1;
		insn = word;
		cur_delay = delay;
		do
			@(negedge clk);
		while (!insn_ready);
		@(posedge clk);
		#1;
		insn_valid = 1'b0;
	endtask

	task automatic wait_drained();
		do
			@(posedge clk);
		while (outstanding != 0);
		#1;
	endtask

	// Earliest due result goes out first
	task automatic drive_ext_result();
		int pick;
		pick = -1;
		foreach (ext_due_q[i])
			if (ext_due_q[i] <= cycle && (pick < 0 || ext_due_q[i] < ext_due_q[pick]))
				pick = i;
		if (pick >= 0) begin
			ext_result.valid = 1'b1;
			ext_result.tag = ext_tag_q[pick];
			ext_result.data = ext_val_q[pick];
			ext_tag_q.delete(pick);
			ext_val_q.delete(pick);
			ext_due_q.delete(pick);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		forever begin
			@(posedge clk);
			#1;
			cycle++;
			if (ext_taken) begin
				ext_result.valid = 1'b0;
				ext_taken = 1'b0;
			end
			if (!ext_result.valid)
				drive_ext_result();
		end
	end

	always @(negedge clk) begin
		logic [31:0] w;
		logic [31:0] v;
		logic xfer;
		if (!reset) begin
			w = insn;
			xfer = insn_valid && insn_ready;
			if (insn_valid && !insn_ready)
				stall_seen = 1'b1;
			check("ext_issue_valid", 32'(ext_issue_valid), 32'(xfer && w[31:30] == 2'd2));
			if (xfer) begin
				check("pending[new tag]", 32'(pending[ref_tag]), 32'h0);
				case (w[31:30])
					2'd0: v = {{16{w[15]}}, w[15:0]};
					2'd1: v = ref_reg[w[25:22]];
					default: begin
						check("ext_issue", 32'(ext_issue), 32'(ref_tag));
						v = next_random(32);
						ext_tag_q.push_back(ref_tag);
						ext_val_q.push_back(v);
						ext_due_q.push_back(cycle + int'(cur_delay));
					end
				endcase
				ref_reg[w[29:26]] = v;
				exp_val[ref_tag] = v;
				pending[ref_tag] = 1'b1;
				readback[ref_tag] = rb_phase;
				rb_reg[ref_tag] = w[29:26];
				ref_tag++;
				outstanding++;
			end
			// External results always win the CDB
			if (ext_result.valid) begin
				check("ext_result_ready", 32'(ext_result_ready), 32'h1);
				check("cdb_out.valid", 32'(cdb_out.valid), 32'h1);
				check("cdb_out.tag", 32'(cdb_out.tag), 32'(ext_result.tag));
				if (ext_result_ready)
					ext_taken = 1'b1;
			end
			if (cdb_out.valid) begin
				check("pending[cdb_out.tag]", 32'(pending[cdb_out.tag]), 32'h1);
				check("cdb_out.data", cdb_out.data, exp_val[cdb_out.tag]);
				if (readback[cdb_out.tag])
					check("cdb_out.data", cdb_out.data, tests[exp_base + rb_reg[cdb_out.tag]][31:0]);
				pending[cdb_out.tag] = 1'b0;
				outstanding--;
			end
		end
	end

	initial begin
		wait (n_lines > 0);
		repeat (n_lines * 50) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", n_lines * 50);
		$display("STATUS: FAIL");
		$fatal(1);
	end

	initial begin
		reset = 1'b1;
		insn_valid = 1'b0;
		insn = '0;
		ext_result = '0;
		cur_delay = '0;
		lfsr = 32'h5c3a;
		cycle = 0;
		ext_taken = 1'b0;
		ref_tag = '0;
		outstanding = 0;
		stall_seen = 1'b0;
		rb_phase = 1'b0;
		for (int i = 0; i < 16; i++)
			ref_reg[i] = '0;
		for (int i = 0; i < 8; i++) begin
			pending[i] = 1'b0;
			readback[i] = 1'b0;
		end
		for (int i = 0; i <= exp_base + 15; i++)
			tests[i] = '1;
		$readmemh("test/mov_core_tests.txt", tests);
		n_prog = 0;
		while (n_prog < exp_base && tests[n_prog][31:30] != 2'b11)
			n_prog++;
		n_lines = n_prog + 16;

		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check("insn_ready", 32'(insn_ready), 32'h1);
		check("cdb_out.valid", 32'(cdb_out.valid), 32'h0);
		check("ext_issue_valid", 32'(ext_issue_valid), 32'h0);
		@(posedge clk);
		#1;

		for (int i = 0; i < n_prog; i++)
			send_insn(tests[i][31:0], tests[i][39:32]);
		wait_drained();

		// Copy each register onto itself so its value shows on the CDB
		rb_phase = 1'b1;
		for (int r = 0; r < 16; r++)
			send_insn({2'b01, 4'(r), 4'(r), 22'b0}, 8'h0);
		wait_drained();

		check("stall_seen", 32'(stall_seen), 32'h1);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/cdb_arbiter.sv ====
`default_nettype none

module cdb_arbiter (
	input wire core_pkg::cdb_t ext_result,
	output logic ext_result_ready,
	input wire mov_req_valid,
	output logic mov_req_ready,
	input wire core_pkg::tag_t mov_req_tag,
	input wire [31:0] mov_req_data,
	output core_pkg::cdb_t cdb
);
	// External results always win, so they never wait
	assign ext_result_ready = 1'b1;
	assign mov_req_ready = !ext_result.valid;

	always_comb begin
		if (ext_result.valid) begin
			cdb = ext_result;
		end else begin
			cdb.valid = mov_req_valid;
			cdb.tag = mov_req_tag;
			cdb.data = mov_req_data;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/core_pkg.sv ====
`default_nettype none

package core_pkg;

	// Eight tags, at most seven of them in flight
	localparam int tag_width = 3;

	typedef logic [tag_width-1:0] tag_t;

	// Shared by CDB broadcasts and register-read operands
	// For an operand, valid means data is present, else it waits on tag
	typedef struct packed {
		logic        valid;
		tag_t        tag;
		logic [31:0] data;
	} cdb_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		cdb_t opd;
	} mov_entry_t;

	typedef struct packed {
		tag_t        tag;
		logic        is_imm;
		logic [31:0] imm;
	} issue_t;

endpackage

`default_nettype wire

// ==== verilog/gpr_rename_file.sv ====
`default_nettype none

module gpr_rename_file (
	input wire clk,
	input wire reset,
	input wire isa_pkg::reg_idx_t src_idx,
	output core_pkg::cdb_t src_opd,
	input wire alloc_valid,
	input wire isa_pkg::reg_idx_t dst_idx,
	input wire core_pkg::tag_t alloc_tag,
	input wire core_pkg::cdb_t cdb
);
	logic [31:0] value [isa_pkg::reg_count];
	logic busy [isa_pkg::reg_count];
	core_pkg::tag_t prod_tag [isa_pkg::reg_count];

	always_comb begin
		src_opd.valid = !busy[src_idx];
		src_opd.tag = prod_tag[src_idx];
		src_opd.data = value[src_idx];
		// Producer broadcasting right now
		if (busy[src_idx] && cdb.valid && cdb.tag == prod_tag[src_idx]) begin
			src_opd.valid = 1'b1;
			src_opd.data = cdb.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < isa_pkg::reg_count; i++) begin
				value[i] <= '0;
				busy[i] <= 1'b0;
			end
		end else begin
			for (int i = 0; i < isa_pkg::reg_count; i++) begin
				if (alloc_valid && dst_idx == isa_pkg::reg_idx_t'(i)) begin
					// New move may broadcast in its own issue cycle
					if (cdb.valid && cdb.tag == alloc_tag) begin
						value[i] <= cdb.data;
						busy[i] <= 1'b0;
					end else begin
						busy[i] <= 1'b1;
					end
				end else if (busy[i] && cdb.valid && cdb.tag == prod_tag[i]) begin
					value[i] <= cdb.data;
					busy[i] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (alloc_valid)
			prod_tag[dst_idx] <= alloc_tag;
	end

endmodule

`default_nettype wire

// ==== verilog/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	localparam int reg_count = 16;

	typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

	typedef enum logic [1:0] {
		op_mov_imm = 2'd0,
		op_mov_reg = 2'd1,
		op_ext     = 2'd2
	} opcode_t;

	// Opcode and destination sit in the same bits in both forms
	typedef struct packed {
		opcode_t     opcode;
		reg_idx_t    dst;
		logic [9:0]  rsvd;
		logic [15:0] imm;
	} imm_form_t;

	typedef struct packed {
		opcode_t     opcode;
		reg_idx_t    dst;
		reg_idx_t    src;
		logic [21:0] rsvd;
	} reg_form_t;

	typedef union packed {
		imm_form_t imm_form;
		reg_form_t reg_form;
	} insn_t;

endpackage

`default_nettype wire

// ==== verilog/issue_unit.sv ====
`default_nettype none

module issue_unit (
	input wire clk,
	input wire reset,
	input wire insn_valid,
	output logic insn_ready,
	input wire isa_pkg::insn_t insn,
	output isa_pkg::reg_idx_t src_idx,
	output isa_pkg::reg_idx_t dst_idx,
	output logic alloc_valid,
	output core_pkg::tag_t alloc_tag,
	input wire core_pkg::cdb_t src_opd,
	output logic issue_valid,
	input wire station_ready,
	output core_pkg::issue_t issue,
	output logic ext_issue_valid,
	output core_pkg::tag_t ext_issue,
	input wire core_pkg::cdb_t cdb
);
	localparam int max_inflight = (1 << core_pkg::tag_width) - 1;

	isa_pkg::opcode_t opcode;
	logic is_ext;
	logic tags_full;
	logic transfer;
	core_pkg::tag_t next_tag;
	logic [core_pkg::tag_width:0] inflight;
	logic [(1 << core_pkg::tag_width)-1:0] tag_busy;

	// Opcode and constant from the immediate view, register fields from the other
	assign opcode = insn.imm_form.opcode;
	assign src_idx = insn.reg_form.src;
	assign dst_idx = insn.reg_form.dst;
	assign is_ext = opcode == isa_pkg::op_ext;

	// Tags come back out of order, so the next one may still be in flight
	assign tags_full = inflight == max_inflight || tag_busy[next_tag];
	assign issue_valid = insn_valid && !is_ext && !tags_full;
	assign insn_ready = !tags_full && (is_ext || station_ready);
	assign transfer = insn_valid && insn_ready;

	assign alloc_valid = transfer;
	assign alloc_tag = next_tag;
	assign ext_issue_valid = transfer && is_ext;
	assign ext_issue = next_tag;

	assign issue.tag = next_tag;
	assign issue.is_imm = opcode == isa_pkg::op_mov_imm;
	assign issue.imm = {{16{insn.imm_form.imm[15]}}, insn.imm_form.imm};

	always_ff @(posedge clk) begin
		if (reset) begin
			next_tag <= '0;
			inflight <= '0;
			tag_busy <= '0;
		end else begin
			if (transfer) begin
				next_tag <= next_tag + core_pkg::tag_t'(1);
				tag_busy[next_tag] <= 1'b1;
			end
			// A new move may broadcast in its own issue cycle
			if (cdb.valid)
				tag_busy[cdb.tag] <= 1'b0;
			case ({transfer, cdb.valid})
				2'b10: inflight <= inflight + (core_pkg::tag_width+1)'(1);
				2'b01: inflight <= inflight - (core_pkg::tag_width+1)'(1);
				default: ;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) inflight <= max_inflight);

	// A waiting source must name a tag still in flight
	assert property (@(posedge clk) disable iff (reset)
		transfer && opcode == isa_pkg::op_mov_reg && !src_opd.valid
		|-> tag_busy[src_opd.tag]);

endmodule

`default_nettype wire

// ==== verilog/mov_core.sv ====
`default_nettype none

module mov_core #(
	parameter int n_entry = 2
) (
	input wire clk,
	input wire reset,
	input wire insn_valid,
	output logic insn_ready,
	input wire isa_pkg::insn_t insn,
	output logic ext_issue_valid,
	output core_pkg::tag_t ext_issue,
	input wire core_pkg::cdb_t ext_result,
	output logic ext_result_ready,
	output core_pkg::cdb_t cdb_out
);
	isa_pkg::reg_idx_t src_idx;
	isa_pkg::reg_idx_t dst_idx;
	logic alloc_valid;
	core_pkg::tag_t alloc_tag;
	core_pkg::cdb_t src_opd;
	logic issue_valid;
	logic station_ready;
	core_pkg::issue_t issue;
	logic mov_req_valid;
	logic mov_req_ready;
	core_pkg::tag_t mov_req_tag;
	logic [31:0] mov_req_data;
	core_pkg::cdb_t cdb;

	issue_unit u_issue (
		.clk(clk), .reset(reset),
		.insn_valid(insn_valid), .insn_ready(insn_ready), .insn(insn),
		.src_idx(src_idx), .dst_idx(dst_idx),
		.alloc_valid(alloc_valid), .alloc_tag(alloc_tag), .src_opd(src_opd),
		.issue_valid(issue_valid), .station_ready(station_ready), .issue(issue),
		.ext_issue_valid(ext_issue_valid), .ext_issue(ext_issue),
		.cdb(cdb)
	);

	gpr_rename_file u_gpr (
		.clk(clk), .reset(reset),
		.src_idx(src_idx), .src_opd(src_opd),
		.alloc_valid(alloc_valid), .dst_idx(dst_idx), .alloc_tag(alloc_tag),
		.cdb(cdb)
	);

	mov_station #(.n_entry(n_entry)) u_mov (
		.clk(clk), .reset(reset),
		.issue_valid(issue_valid), .station_ready(station_ready), .issue(issue),
		.src_opd(src_opd), .cdb(cdb),
		.mov_req_valid(mov_req_valid), .mov_req_ready(mov_req_ready),
		.mov_req_tag(mov_req_tag), .mov_req_data(mov_req_data)
	);

	cdb_arbiter u_arb (
		.ext_result(ext_result), .ext_result_ready(ext_result_ready),
		.mov_req_valid(mov_req_valid), .mov_req_ready(mov_req_ready),
		.mov_req_tag(mov_req_tag), .mov_req_data(mov_req_data),
		.cdb(cdb)
	);

	assign cdb_out = cdb;

endmodule

`default_nettype wire

// ==== verilog/mov_station.sv ====
`default_nettype none

module mov_station #(
	parameter int n_entry = 2
) (
	input wire clk,
	input wire reset,
	input wire issue_valid,
	output logic station_ready,
	input wire core_pkg::issue_t issue,
	input wire core_pkg::cdb_t src_opd,
	input wire core_pkg::cdb_t cdb,
	output logic mov_req_valid,
	input wire mov_req_ready,
	output core_pkg::tag_t mov_req_tag,
	output logic [31:0] mov_req_data
);
	localparam int sel_w = $clog2(n_entry + 1);

	// Slot 0 holds the oldest move
	core_pkg::mov_entry_t e [n_entry];
	core_pkg::mov_entry_t e_upd [n_entry];
	core_pkg::mov_entry_t nxt [n_entry];
	core_pkg::mov_entry_t e_new;
	core_pkg::mov_entry_t cand [n_entry+1];
	logic [sel_w-1:0] sel;
	logic dispatch;
	logic take;

	always_comb begin
		e_new.valid = issue_valid;
		e_new.tag = issue.tag;
		e_new.opd.valid = issue.is_imm || src_opd.valid;
		e_new.opd.tag = src_opd.tag;
		e_new.opd.data = issue.is_imm ? issue.imm : src_opd.data;
	end

	// Tag wake-up
	always_comb begin
		for (int i = 0; i < n_entry; i++) begin
			e_upd[i] = e[i];
			if (!e[i].opd.valid && cdb.valid && cdb.tag == e[i].opd.tag) begin
				e_upd[i].opd.valid = 1'b1;
				e_upd[i].opd.data = cdb.data;
			end
		end
	end

	// Oldest ready candidate, incoming move last
	always_comb begin
		for (int i = 0; i < n_entry; i++)
			cand[i] = e_upd[i];
		cand[n_entry] = e_new;
		mov_req_valid = 1'b0;
		sel = sel_w'(n_entry);
		for (int i = n_entry; i >= 0; i--) begin
			if (cand[i].valid && cand[i].opd.valid) begin
				mov_req_valid = 1'b1;
				sel = sel_w'(i);
			end
		end
		mov_req_tag = cand[sel].tag;
		mov_req_data = cand[sel].opd.data;
	end

	assign dispatch = mov_req_valid && mov_req_ready;
	assign station_ready = dispatch || !e[n_entry-1].valid;
	assign take = issue_valid && station_ready && !(dispatch && int'(sel) == n_entry);

	// Shift down past the dispatched slot, then append the new move
	always_comb begin
		logic placed;
		placed = 1'b0;
		for (int i = 0; i < n_entry; i++) begin
			if (dispatch && int'(sel) <= i) begin
				if (i + 1 < n_entry) begin
					nxt[i] = e_upd[i+1];
				end else begin
					nxt[i] = e_upd[i];
					nxt[i].valid = 1'b0;
				end
			end else begin
				nxt[i] = e_upd[i];
			end
			if (!nxt[i].valid && take && !placed) begin
				nxt[i] = e_new;
				placed = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < n_entry; i++) begin
			if (reset)
				e[i].valid <= 1'b0;
			else
				e[i] <= nxt[i];
		end
	end

	for (genvar i = 1; i < n_entry; i++) begin : g_packed
		assert property (@(posedge clk) disable iff (reset) e[i].valid |-> e[i-1].valid);
	end

endmodule

`default_nettype wire
